// File: hdl/mem_hier_settings.svh
`ifndef MEM_HIER_SETTINGS_SVH
`define MEM_HIER_SETTINGS_SVH

// Cache geometry
`define MH_LINES 64           // Lines in each cache
`define MH_WORDS_PER_LINE 4   // Words per cache line

// Backing memory
`define MH_MEM_LINES 16384    // Lines in the unified memory
`define MH_MEM_LATENCY 4      // First request cycle to ready, inclusive

`endif

// File: hdl/mem_hier_pkg.sv
package mem_hier_pkg;

	// Address fields from the top bit down are tag, index and offset
	typedef logic [15:0] word_addr_t;  // Processor word address
	typedef logic [13:0] line_addr_t;  // Word address without its offset
	typedef logic [7:0]  tag_t;        // Upper address bits kept per line
	typedef logic [5:0]  index_t;      // Selects one of the cache lines
	typedef logic [1:0]  offset_t;     // Word inside a line

	typedef logic [15:0] word_t;       // Processor data word
	typedef logic [63:0] line_t;       // Four words with word 0 in the low bits

	// Controller FSM states
	typedef enum logic [1:0] {
		START        = 2'b00,
		EXTRA        = 2'b01,
		SERVICE_MISS = 2'b10,
		WRITE_BACK   = 2'b11
	} ctrl_state_t;

	// Controller to cache write command
	typedef struct packed {
		logic  we;     // Store on this clock edge
		line_t line;   // Full line to store
		logic  dirty;  // New dirty bit for the data cache only
	} cache_wr_t;

	// Controller to backing memory
	typedef struct packed {
		logic       rd;    // Read strobe held until ready
		logic       wr;    // Write strobe held until ready
		line_addr_t addr;  // Line being read or written
		line_t      line;  // Write line
	} mem_req_t;

	// Data cache lookup result
	typedef struct packed {
		logic  hit;    // Valid and tag match
		logic  dirty;  // Stored line differs from memory
		tag_t  tag;    // Tag of the stored line
		line_t line;   // Stored line
	} dcache_stat_t;

endpackage

// File: hdl/icache.sv
`timescale 1ns/1ps
`include "mem_hier_settings.svh"

module icache import mem_hier_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  word_addr_t i_addr,  // Fetch address
	input  cache_wr_t  i_wr,    // Refill from the controller
	output logic       o_hit,
	output word_t      o_word   // Fetched word
);

	localparam int unsigned WORD_BITS = $bits(line_t) / `MH_WORDS_PER_LINE;

	tag_t    tag;
	index_t  idx;
	offset_t off;

	tag_t  tags  [`MH_LINES];  // Stored tags
	line_t lines [`MH_LINES];
	logic [`MH_LINES-1:0] valid;

	line_t cur_line;

	assign tag = i_addr[15:8];
	assign idx = i_addr[7:2];
	assign off = i_addr[1:0];

	assign cur_line = lines[idx];  // Asynchronous array read
	assign o_hit    = valid[idx] && (tags[idx] == tag);
	assign o_word   = cur_line[off*WORD_BITS +: WORD_BITS];

	// Valid bits clear on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (i_wr.we) begin
			valid[idx] <= 1'b1;
		end
	end

	// Refill stores line and tag at the fetch index
	always_ff @(posedge clk) begin
		if (i_wr.we) begin
			lines[idx] <= i_wr.line;
			tags[idx]  <= tag;
		end
	end

endmodule

// File: hdl/dcache.sv
`timescale 1ns/1ps
`include "mem_hier_settings.svh"

module dcache import mem_hier_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  word_addr_t   i_addr,  // Data address
	input  cache_wr_t    i_wr,    // Refill or write-hit merge
	output dcache_stat_t o_stat   // Lookup result for the controller
);

	tag_t   tag;
	index_t idx;

	tag_t  tags  [`MH_LINES];  // Stored tags
	line_t lines [`MH_LINES];  // Stored lines
	logic [`MH_LINES-1:0] valid;
	logic [`MH_LINES-1:0] dirty;

	assign tag = i_addr[15:8];
	assign idx = i_addr[7:2];

	// Lookup is purely combinational
	always_comb begin
		o_stat.hit   = valid[idx] && (tags[idx] == tag);
		o_stat.dirty = valid[idx] && dirty[idx];  // Only a valid line can need write-back
		o_stat.tag   = tags[idx];
		o_stat.line  = lines[idx];
	end

	// Control bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_wr.we) begin
			valid[idx] <= 1'b1;
			dirty[idx] <= i_wr.dirty;  // Clean on refill, set on merge
		end
	end

	// Payload arrays
	always_ff @(posedge clk) begin
		if (i_wr.we) begin
			lines[idx] <= i_wr.line;
			tags[idx]  <= tag;  // Replaces the evicted tag
		end
	end

endmodule

// File: hdl/unified_mem.sv
`timescale 1ns/1ps
`include "mem_hier_settings.svh"

module unified_mem import mem_hier_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t i_req,   // Held by the controller until ready
	output logic     o_rdy,   // One-cycle pulse at the end of the latency
	output line_t    o_line   // Read line, valid while ready is high
);

	localparam int unsigned CNT_W = $clog2(`MH_MEM_LATENCY + 1);

	line_t mem [`MH_MEM_LINES];  // Line-wide storage

	logic             strobe;
	logic [CNT_W-1:0] cnt;  // Cycles of the current request already spent

	assign strobe = i_req.rd | i_req.wr;

	// Ready in the last latency cycle of a held request
	assign o_rdy = strobe && (cnt == CNT_W'(`MH_MEM_LATENCY - 1));

	// Counter restarts after each ready so back-to-back requests count afresh
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!strobe || o_rdy) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Write lands at the closing edge of the ready cycle
	always_ff @(posedge clk) begin
		if (i_req.wr && o_rdy) begin
			mem[i_req.addr] <= i_req.line;
		end
	end

	// Read is asynchronous, the controller only samples it with ready
	assign o_line = mem[i_req.addr];

endmodule

// File: hdl/cache_controller.sv
`timescale 1ns/1ps
`include "mem_hier_settings.svh"

module cache_controller import mem_hier_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  word_addr_t   i_i_addr,   // Fetch address
	input  word_addr_t   i_d_addr,   // Data address
	input  word_t        i_wr_data,  // Store data
	input  logic         i_i_acc,    // Fetch requested
	input  logic         i_d_acc,    // Data read or write requested
	input  logic         i_write,    // Data access is a store
	input  logic         i_i_hit,
	input  dcache_stat_t i_d_stat,
	input  logic         i_mem_rdy,
	input  line_t        i_m_line,   // Line read from memory
	output cache_wr_t    o_i_wr,
	output cache_wr_t    o_d_wr,
	output mem_req_t     o_m_req,
	output word_t        o_rd_data,  // Load result
	output logic         o_rdy       // Processor may complete its access
);

	localparam int unsigned WORD_BITS = $bits(line_t) / `MH_WORDS_PER_LINE;

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic       d_miss;
	logic       i_miss;
	offset_t    d_off;
	line_addr_t d_line_addr;
	line_addr_t i_line_addr;
	line_addr_t wb_addr;

	// Clear the addressed word, then drop the store data into the gap
	function automatic line_t merge_word(line_t base, offset_t off, word_t data);
		line_t mask;
		line_t ins;
		mask = line_t'({WORD_BITS{1'b1}}) << (off * WORD_BITS);
		ins  = line_t'(data) << (off * WORD_BITS);
		return (base & ~mask) | ins;
	endfunction

	assign d_miss      = i_d_acc && !i_d_stat.hit;
	assign i_miss      = i_i_acc && !i_i_hit;
	assign d_off       = i_d_addr[1:0];
	assign d_line_addr = i_d_addr[15:2];
	assign i_line_addr = i_i_addr[15:2];
	assign wb_addr     = {i_d_stat.tag, i_d_addr[7:2]};  // Line now held in the cache

	// Load data comes straight from the cached line
	assign o_rd_data = i_d_stat.line[d_off*WORD_BITS +: WORD_BITS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= START;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		o_i_wr       = '0;
		o_d_wr       = '0;
		o_m_req      = '0;
		o_m_req.line = i_d_stat.line;  // Only meaningful during write-back
		o_rdy        = 1'b0;
		next_state   = START;

		case (state)
			START: begin
				if (d_miss) begin  // Data side first
					if (i_d_stat.dirty) begin
						o_m_req.wr   = 1'b1;
						o_m_req.addr = wb_addr;
						next_state   = WRITE_BACK;
					end else begin
						o_m_req.rd   = 1'b1;
						o_m_req.addr = d_line_addr;
						next_state   = SERVICE_MISS;
					end
				end else if (i_miss) begin
					o_m_req.rd   = 1'b1;
					o_m_req.addr = i_line_addr;
					next_state   = SERVICE_MISS;
				end else begin
					if (i_d_acc && i_write) begin  // Write hit merges and marks dirty
						o_d_wr.we    = 1'b1;
						o_d_wr.line  = merge_word(i_d_stat.line, d_off, i_wr_data);
						o_d_wr.dirty = 1'b1;
					end
					o_rdy = 1'b1;
				end
			end

			SERVICE_MISS: begin
				if (d_miss) begin
					o_m_req.rd   = 1'b1;  // Keep request steady until ready
					o_m_req.addr = d_line_addr;
					if (i_mem_rdy) begin
						o_d_wr.we = 1'b1;
						if (i_write) begin  // Write miss
							o_d_wr.line  = merge_word(i_m_line, d_off, i_wr_data);
							o_d_wr.dirty = 1'b1;
						end else begin
							o_d_wr.line = i_m_line;
						end
					end
				end else if (i_miss) begin
					o_m_req.rd   = 1'b1;
					o_m_req.addr = i_line_addr;
					if (i_mem_rdy) begin
						o_i_wr.we   = 1'b1;
						o_i_wr.line = i_m_line;
					end
				end
				// Back to START after the refill, where the access then hits
				if (!i_mem_rdy && (d_miss || i_miss)) begin
					next_state = SERVICE_MISS;
				end
			end

			WRITE_BACK: begin
				o_m_req.wr   = 1'b1;
				o_m_req.addr = wb_addr;
				next_state   = i_mem_rdy ? EXTRA : WRITE_BACK;
			end

			EXTRA: begin
				// Fresh read after the write-back, the old ready must not count as refill
				o_m_req.rd   = 1'b1;
				o_m_req.addr = d_line_addr;
				next_state   = SERVICE_MISS;
			end

			default: begin
				next_state = START;
			end
		endcase
	end

endmodule

// File: hdl/mem_hier.sv
`timescale 1ns/1ps

module mem_hier import mem_hier_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  word_addr_t i_i_addr,   // Fetch address
	input  logic       i_i_acc,    // Fetch request
	input  word_addr_t i_d_addr,   // Data address
	input  word_t      i_wr_data,  // Store data
	input  logic       i_read,     // Load request
	input  logic       i_write,    // Store request
	output word_t      o_instr,    // Fetched word
	output word_t      o_rd_data,  // Loaded word
	output logic       o_rdy       // All active accesses done
);

	logic         d_acc;
	logic         i_hit;
	word_t        i_word;
	dcache_stat_t d_stat;
	cache_wr_t    i_wr;
	cache_wr_t    d_wr;
	mem_req_t     m_req;
	logic         mem_rdy;
	line_t        m_line;

	assign d_acc   = i_read | i_write;
	assign o_instr = i_word;

	cache_controller u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_addr  (i_i_addr),
		.i_d_addr  (i_d_addr),
		.i_wr_data (i_wr_data),
		.i_i_acc   (i_i_acc),
		.i_d_acc   (d_acc),
		.i_write   (i_write),
		.i_i_hit   (i_hit),
		.i_d_stat  (d_stat),
		.i_mem_rdy (mem_rdy),
		.i_m_line  (m_line),
		.o_i_wr    (i_wr),
		.o_d_wr    (d_wr),
		.o_m_req   (m_req),
		.o_rd_data (o_rd_data),
		.o_rdy     (o_rdy)
	);

	icache u_icache (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_addr (i_i_addr),
		.i_wr   (i_wr),
		.o_hit  (i_hit),
		.o_word (i_word)
	);

	dcache u_dcache (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_addr (i_d_addr),
		.i_wr   (d_wr),
		.o_stat (d_stat)
	);

	unified_mem u_mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_req  (m_req),
		.o_rdy  (mem_rdy),
		.o_line (m_line)
	);

endmodule

// File: test/mem_hier_tb.sv
`timescale 1ns/1ps
`include "mem_hier_settings.svh"

module mem_hier_tb import mem_hier_pkg::*; ();

	localparam int CLK_HALF  = 20;                        // 40 ns period
	localparam int RST_CYC   = 10;                        // Reset length in cycles
	localparam int DRIVE_DLY = 2;                         // Input skew after the rising edge
	localparam int CASE_CYC  = 2 * `MH_MEM_LATENCY + 8;   // Budget per case
	localparam int MISS2_MIN = 2 * `MH_MEM_LATENCY;       // Least wait for two memory reads

	logic       clk = 1'b0;
	logic       rst_n;
	word_addr_t i_i_addr;
	logic       i_i_acc;
	word_addr_t i_d_addr;
	word_t      i_wr_data;
	logic       i_read;
	logic       i_write;
	word_t      o_instr;
	word_t      o_rd_data;
	logic       o_rdy;

	logic [7:0] case_op    [$];  // W, R, F or B
	word_addr_t case_addr  [$];
	word_t      case_wdata [$];
	word_t      case_exp   [$];  // Expected fetch or load word

	int n_mismatch = 0;
	int n_other    = 0;  // Timeouts, bad file lines, early ready
	bit loaded     = 1'b0;

	mem_hier i_mem_hier (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_addr  (i_i_addr),
		.i_i_acc   (i_i_acc),
		.i_d_addr  (i_d_addr),
		.i_wr_data (i_wr_data),
		.i_read    (i_read),
		.i_write   (i_write),
		.o_instr   (o_instr),
		.o_rd_data (o_rd_data),
		.o_rdy     (o_rdy)
	);

	always #CLK_HALF clk = ~clk;

	// Reads the whole case file into the queues before the run starts
	task automatic load_cases();
		int               fd;
		int               code;
		logic [7:0]       op;
		word_addr_t       addr;
		word_t            wdata;
		word_t            exp;
		logic [8*256-1:0] rest;  // Remainder of a comment line
		fd = $fopen("test/mem_hier_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file test/mem_hier_cases.txt");
			n_other++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", op);  // Skips blank space, -1 at end of file
				if (code == 1) begin
					if (op == "#") begin
						code = $fgets(rest, fd);
					end else begin
						code = $fscanf(fd, " %h %h %h", addr, wdata, exp);
						if (code == 3) begin
							case_op.push_back(op);
							case_addr.push_back(addr);
							case_wdata.push_back(wdata);
							case_exp.push_back(exp);
						end else begin
							$display("Case line starting with %c is malformed", op);
							n_other++;
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Drives one operation, waits for ready, checks, then idles one cycle
	task automatic run_case(input int k);
		logic [7:0] op;
		int         wait_cyc;  // Cycles with ready low
		op        = case_op[k];
		wait_cyc  = 0;
		i_i_addr  = case_addr[k];
		i_d_addr  = case_addr[k];
		i_wr_data = case_wdata[k];
		i_i_acc   = (op == "F") || (op == "B");
		i_read    = (op == "R") || (op == "B");
		i_write   = (op == "W");
		if (op != "W" && op != "R" && op != "F" && op != "B") begin
			$display("Case %0d has an unknown operation %c", k, op);
			n_other++;
		end

		// Negedge sample, nothing changes again before the rising edge
		@(negedge clk);
		while (o_rdy !== 1'b1) begin
			wait_cyc++;
			@(negedge clk);
		end

		if ((op == "R" || op == "B") && o_rd_data !== case_exp[k]) begin
			$display("MISMATCH case %0d %c 0x%04h: o_rd_data expected 0x%04h got 0x%04h",
				k, op, case_addr[k], case_exp[k], o_rd_data);
			n_mismatch++;
		end
		if ((op == "F" || op == "B") && o_instr !== case_exp[k]) begin
			$display("MISMATCH case %0d %c 0x%04h: o_instr expected 0x%04h got 0x%04h",
				k, op, case_addr[k], case_exp[k], o_instr);
			n_mismatch++;
		end
		// A B case misses on both sides, so two memory reads must fit before ready
		if (op == "B" && wait_cyc < MISS2_MIN) begin
			$display("Case %0d: ready rose after %0d cycles, too early for two misses",
				k, wait_cyc);
			n_other++;
		end

		@(posedge clk);  // Access closes here
		#DRIVE_DLY;
		i_i_acc = 1'b0;
		i_read  = 1'b0;
		i_write = 1'b0;
		@(posedge clk);  // One idle cycle between cases
		#DRIVE_DLY;
	endtask

	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = case_op.size() * CASE_CYC + 20;  // Covers reset too
		repeat (limit) @(posedge clk);
		$display("Run timed out after %0d cycles while waiting for ready", limit);
		$display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_other + 1);
		$display("tests failed");
		$finish;
	end

	initial begin
		rst_n     = 1'b0;
		i_i_addr  = '0;
		i_i_acc   = 1'b0;
		i_d_addr  = '0;
		i_wr_data = '0;
		i_read    = 1'b0;
		i_write   = 1'b0;

		load_cases();
		loaded = 1'b1;
		if (case_op.size() == 0) begin
			$display("No cases were loaded");
			n_other++;
		end

		repeat (RST_CYC) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;

		for (int k = 0; k < case_op.size(); k++) begin
			run_case(k);
		end

		$display("Errors: %0d mismatches, %0d other failures over %0d cases",
			n_mismatch, n_other, case_op.size());
		if (n_mismatch + n_other == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: mem_hier.f
+incdir+hdl
hdl/mem_hier_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/unified_mem.sv
hdl/cache_controller.sv
hdl/mem_hier.sv
test/mem_hier_tb.sv

// File: test/mem_hier_cases.txt
# op addr wdata expected, all hex; W write, R read, F fetch, B fetch and read of one address
# expected is checked on R, F and B and ignored on W
W 0104 AAAA 0000
R 0104 0000 AAAA
W 0105 BBBB 0000
W 0106 CCCC 0000
R 0105 0000 BBBB
R 0104 0000 AAAA
R 0106 0000 CCCC
W 0207 1234 0000
R 0207 0000 1234
F 0104 0000 AAAA
F 0106 0000 CCCC
R 0104 0000 AAAA
R 0105 0000 BBBB
B 0207 0000 1234
W 0310 5555 0000
W 0410 6666 0000
B 0310 0000 5555
R 0410 0000 6666
W 0000 0001 0000
R 0000 0000 0001
W FF00 0F0F 0000
R FF00 0000 0F0F
R 0000 0000 0001
W 00FD DEAD 0000
W 01FD BEEF 0000
R 01FD 0000 BEEF
R 00FD 0000 DEAD
F 00FD 0000 DEAD
